// ==== tb/id_trace.txt ====
# I av fv inst pc es_we es_wa es_res es_ld ms_we ms_wa ms_wd ws_we ws_wa ws_wd
# E allowin br_taken br_target valid pc alu_op mem_op src1 src2 rkd rf_we waddr
# hex values; br_target is compared only when br_taken is expected high
# seed r1 r2 r3 through writeback, check reset state
I 1 0 00000000 00000000 0 00 00000000 0 0 00 00000000 1 01 00000010
E 1 0 00000000 0 1bffffff 0 0 00000000 00000000 00000000 0 00
I 1 0 00000000 00000000 0 00 00000000 0 0 00 00000000 1 02 fffffff0
I 1 1 00100824 1c000000 0 00 00000000 0 0 00 00000000 1 03 00000003
# alu register and immediate forms
I 1 1 00110465 1c000004 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000000 1 0 00000010 fffffff0 fffffff0 1 04
I 1 1 00128c46 1c000008 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000004 2 0 00000003 00000010 00000010 1 05
I 1 1 02a00047 1c00000c 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000008 4 0 fffffff0 00000003 00000003 1 06
I 1 1 03a00428 1c000010 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c00000c 1 0 fffffff0 fffff800 00000000 1 07
I 1 1 00488c49 1c000014 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000010 7 0 00000010 00000801 00000010 1 08
I 1 1 1557002a 1c000018 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000014 b 0 fffffff0 00000003 00000003 1 09
I 1 1 1c00002b 1c00001c 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000018 c 0 00000010 ab801000 00000000 1 0a
# load and store
I 1 1 28be002c 1c000020 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c00001c 1 0 1c00001c 00001000 00000000 1 0b
I 1 1 29402043 1c000024 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000020 1 3 00000010 ffffff80 00000000 1 0c
I 1 1 0010006d 1c000028 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000024 1 7 fffffff0 00000008 00000003 0 03
# bypass priority, then r0 never forwarded
I 1 1 0010040e 1c00002c 1 03 11111111 0 1 03 22222222 1 03 33333333
E 1 0 00000000 1 1c000028 1 0 11111111 00000000 00000000 1 0d
I 1 1 0010082f 1c000030 1 00 44444444 0 1 01 55555555 0 00 00000000
E 1 0 00000000 1 1c00002c 1 0 00000000 55555555 55555555 1 0e
# load-use stall for two cycles
I 1 1 58001021 1c000034 1 02 deadbeef 1 0 00 00000000 0 00 00000000
E 0 0 00000000 0 1c000030 1 0 00000010 deadbeef deadbeef 0 0f
I 1 1 58001021 1c000034 1 02 deadbeef 1 0 00 00000000 0 00 00000000
E 0 0 00000000 0 1c000030 1 0 00000010 deadbeef deadbeef 0 0f
I 1 1 58001021 1c000034 0 00 00000000 0 1 02 12345678 0 00 00000000
E 1 0 00000000 1 1c000030 1 0 00000010 12345678 12345678 1 0f
# beq taken, following word dropped
I 1 1 00100425 1c000038 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 1 1c000044 1 1c000034 0 0 00000010 00000010 00000010 0 01
I 1 1 5c001021 1c000044 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 0 1c000038 1 0 00000010 00000010 00000010 0 05
I 1 1 63fff841 1c000048 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000044 0 0 00000010 00000010 00000010 0 01
I 1 0 00000000 00000000 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 1 1c000040 1 1c000048 0 0 fffffff0 00000010 00000010 0 01
I 1 1 68001041 1c000040 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 0 1c000048 0 0 fffffff0 00000010 00000010 0 01
I 1 1 54010000 1c000044 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 1 1c000040 0 0 fffffff0 00000010 00000010 0 01
I 1 0 00000000 00000000 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 1 1c000144 1 1c000044 1 0 1c000044 00000004 00000000 1 01
# jirl held by back-pressure for two cycles
I 1 1 4c008033 1c000144 0 00 00000000 0 0 00 00000000 0 00 00000000
I 0 1 00100000 1c000148 0 00 00000000 0 0 00 00000000 0 00 00000000
E 0 0 00000000 1 1c000144 1 0 1c000144 00000004 00000000 1 13
I 0 1 00100000 1c000148 0 00 00000000 0 0 00 00000000 0 00 00000000
E 0 0 00000000 1 1c000144 1 0 1c000144 00000004 00000000 1 13
I 1 1 00100000 1c000148 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 1 00000090 1 1c000144 1 0 1c000144 00000004 00000000 1 13
I 1 0 00000000 00000000 0 00 00000000 0 0 00 00000000 0 00 00000000
E 1 0 00000000 0 1c000148 1 0 00000000 00000000 00000000 0 00

// ==== sources.f ====
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
tb/id_stage_asserts.sv
tb/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== tb/tb_id_stage.sv ====
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    localparam int clk_period    = 20;
    localparam int reset_cycles  = 10;
    localparam int margin_cycles = 20;

    logic      clk;
    logic      resetn;
    logic      es_allowin;
    logic      fs_to_ds_valid;
    word_t     fs_inst;
    word_t     fs_pc;
    logic      es_rf_we;
    reg_addr_t es_rf_waddr;
    word_t     es_alu_result;
    logic      es_res_from_mem;
    logic      ms_rf_we;
    reg_addr_t ms_rf_waddr;
    word_t     ms_rf_wdata;
    logic      ws_rf_we;
    reg_addr_t ws_rf_waddr;
    word_t     ws_rf_wdata;

    logic      ds_allowin;
    logic      br_taken;
    word_t     br_target;
    logic      ds_to_es_valid;
    word_t     ds_pc;
    alu_op_e   ds_alu_op;
    mem_op_e   ds_mem_op;
    word_t     ds_alu_src1;
    word_t     ds_alu_src2;
    word_t     ds_rkd_value;
    logic      ds_rf_we;
    reg_addr_t ds_rf_waddr;

    string     lines [$];
    int        n_cycles;
    int        n_checks;
    int        errors;
    int        format_errors;
    logic      opened;

    id_stage dut (.*);

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_alu(string name, alu_op_e got, alu_op_e exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_mem(string name, mem_op_e got, mem_op_e exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // trace handling
    ////////////////////////////////////////////////////////////
    task automatic load_trace(output logic ok);
        int    fd;
        string line;
        fd = $fopen("tb/id_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    // only stimulus and expect lines
                    if (line[0] == "I" || line[0] == "E") begin
                        lines.push_back(line);
                        if (line[0] == "I") begin
                            n_cycles++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_inputs(string line);
        logic [31:0] v [14];
        int          n;
        n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                    v[8], v[9], v[10], v[11], v[12], v[13]);
        if (n != 14) begin
            format_errors++;
            $display("trace stimulus line is malformed: %s", line);
        end
        es_allowin      = v[0][0];
        fs_to_ds_valid  = v[1][0];
        fs_inst         = v[2];
        fs_pc           = v[3];
        es_rf_we        = v[4][0];
        es_rf_waddr     = v[5][4:0];
        es_alu_result   = v[6];
        es_res_from_mem = v[7][0];
        ms_rf_we        = v[8][0];
        ms_rf_waddr     = v[9][4:0];
        ms_rf_wdata     = v[10];
        ws_rf_we        = v[11][0];
        ws_rf_waddr     = v[12][4:0];
        ws_rf_wdata     = v[13];
    endtask

    task automatic check_outputs(string line);
        logic [31:0] v [12];
        int          n;
        n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                    v[8], v[9], v[10], v[11]);
        if (n != 12) begin
            format_errors++;
            $display("trace expect line is malformed: %s", line);
        end
        n_checks++;
        check_bit("ds_allowin", ds_allowin, v[0][0]);
        check_bit("br_taken", br_taken, v[1][0]);
        // target matters to fetch only on a redirect
        if (v[1][0]) begin
            check_word("br_target", br_target, v[2]);
        end
        check_bit("ds_to_es_valid", ds_to_es_valid, v[3][0]);
        check_word("ds_pc", ds_pc, v[4]);
        check_alu("ds_alu_op", ds_alu_op, alu_op_e'(v[5][3:0]));
        check_mem("ds_mem_op", ds_mem_op, mem_op_e'(v[6][3:0]));
        check_word("ds_alu_src1", ds_alu_src1, v[7]);
        check_word("ds_alu_src2", ds_alu_src2, v[8]);
        check_word("ds_rkd_value", ds_rkd_value, v[9]);
        check_bit("ds_rf_we", ds_rf_we, v[10][0]);
        check_addr("ds_rf_waddr", ds_rf_waddr, v[11][4:0]);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        clk             = 1'b0;
        resetn          = 1'b0;
        es_allowin      = 1'b0;
        fs_to_ds_valid  = 1'b0;
        fs_inst         = '0;
        fs_pc           = '0;
        es_rf_we        = 1'b0;
        es_rf_waddr     = '0;
        es_alu_result   = '0;
        es_res_from_mem = 1'b0;
        ms_rf_we        = 1'b0;
        ms_rf_waddr     = '0;
        ms_rf_wdata     = '0;
        ws_rf_we        = 1'b0;
        ws_rf_waddr     = '0;
        ws_rf_wdata     = '0;
        n_cycles        = 0;
        n_checks        = 0;
        errors          = 0;
        format_errors   = 0;

        load_trace(opened);
        if (!opened) begin
            $display("could not open the trace file tb/id_trace.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (reset_cycles) @(posedge clk);
            #2 resetn = 1'b1;

            // expect lines check the cycle of the stimulus line above them
            foreach (lines[i]) begin
                if (lines[i][0] == "I") begin
                    @(posedge clk);
                    #2;
                    apply_inputs(lines[i]);
                end else begin
                    #10;
                    check_outputs(lines[i]);
                end
            end
            @(posedge clk);
            #2;

            $display("summary: %0d checks, %0d value errors, %0d trace errors",
                     n_checks, errors, format_errors);
            if (errors == 0 && format_errors == 0 && n_checks > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // watchdog sized from the trace length
    initial begin
        wait (n_cycles > 0);
        #((n_cycles + reset_cycles + margin_cycles) * clk_period);
        $display("watchdog expired, the trace did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb/id_stage_asserts.sv ====
module id_stage_asserts (
    input logic                  clk,
    input logic                  resetn,
    input logic                  es_allowin,
    input logic                  ds_allowin,
    input logic                  ds_valid,
    input logic                  br_taken,
    input logic                  ds_to_es_valid,
    input logic                  ds_rf_we,
    input logic                  es_rf_we,
    input decode_pkg::reg_addr_t es_rf_waddr,
    input logic                  es_res_from_mem,
    input decode_pkg::reg_addr_t raddr1,
    input decode_pkg::reg_addr_t raddr2,
    input logic                  use_src1,
    input logic                  use_src2
);
    timeunit 1ns;
    timeprecision 1ps;

    logic load_match;

    // load in execute writing a source this instruction reads
    assign load_match = es_res_from_mem && es_rf_we && es_rf_waddr != '0 &&
                        ((use_src1 && es_rf_waddr == raddr1) ||
                         (use_src2 && es_rf_waddr == raddr2));

    // fetch redirect only on an accepted branch
    br_needs_handoff: assert property (
        @(posedge clk) disable iff (!resetn)
        br_taken |-> (ds_valid && !load_match && es_allowin && ds_to_es_valid)
    ) else $error("br_taken high without an accepted handoff to execute");

    br_flushes_stage: assert property (
        @(posedge clk) disable iff (!resetn) br_taken |=> !ds_valid
    ) else $error("stage still valid after a taken branch");

    no_valid_on_stall: assert property (
        @(posedge clk) disable iff (!resetn)
        (ds_valid && load_match) |-> (!ds_to_es_valid && !ds_allowin)
    ) else $error("instruction left the stage during a load-use stall");

    we_needs_valid: assert property (
        @(posedge clk) disable iff (!resetn)
        (!ds_valid || load_match) |-> (!ds_to_es_valid && !ds_rf_we)
    ) else $error("ds_rf_we high while ds_to_es_valid is low");

endmodule

bind id_stage id_stage_asserts u_asserts (
    .clk             (clk),
    .resetn          (resetn),
    .es_allowin      (es_allowin),
    .ds_allowin      (ds_allowin),
    .ds_valid        (ds_valid),
    .br_taken        (br_taken),
    .ds_to_es_valid  (ds_to_es_valid),
    .ds_rf_we        (ds_rf_we),
    .es_rf_we        (es_rf_we),
    .es_rf_waddr     (es_rf_waddr),
    .es_res_from_mem (es_res_from_mem),
    .raddr1          (raddr1),
    .raddr2          (raddr2),
    .use_src1        (use_src1),
    .use_src2        (use_src2)
);

// ==== logic/id_stage.sv ====
module id_stage #(
    parameter decode_pkg::word_t reset_pc = 32'h1bff_ffff
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  es_allowin,
    output logic                  ds_allowin,
    output logic                  br_taken,
    output decode_pkg::word_t     br_target,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::word_t     fs_inst,
    input  decode_pkg::word_t     fs_pc,
    output logic                  ds_to_es_valid,
    output decode_pkg::word_t     ds_pc,
    output decode_pkg::alu_op_e   ds_alu_op,
    output decode_pkg::mem_op_e   ds_mem_op,
    output decode_pkg::word_t     ds_alu_src1,
    output decode_pkg::word_t     ds_alu_src2,
    output decode_pkg::word_t     ds_rkd_value,
    output logic                  ds_rf_we,
    output decode_pkg::reg_addr_t ds_rf_waddr,
    input  logic                  es_rf_we,
    input  decode_pkg::reg_addr_t es_rf_waddr,
    input  decode_pkg::word_t     es_alu_result,
    input  logic                  es_res_from_mem,
    input  logic                  ms_rf_we,
    input  decode_pkg::reg_addr_t ms_rf_waddr,
    input  decode_pkg::word_t     ms_rf_wdata,
    input  logic                  ws_rf_we,
    input  decode_pkg::reg_addr_t ws_rf_waddr,
    input  decode_pkg::word_t     ws_rf_wdata
);
    import decode_pkg::*;

    logic      ds_valid;
    logic      ds_ready_go;
    word_t     ds_inst;
    br_op_e    br_op;
    word_t     imm;
    word_t     br_offs;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    logic      rf_we;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      use_src1;
    logic      use_src2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rj_value;
    word_t     rkd_value;
    logic      load_stall;
    logic      cond_taken;

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////
    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    // only once execute takes the branch
    assign br_taken = cond_taken && ds_to_es_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            // word behind a taken branch is dropped
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_inst <= '0;
            ds_pc   <= reset_pc;
        end else if (ds_allowin && fs_to_ds_valid) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // decode, operands, branch
    ////////////////////////////////////////////////////////////
    inst_decoder u_decoder (
        .inst        (ds_inst),
        .alu_op      (ds_alu_op),
        .mem_op      (ds_mem_op),
        .br_op       (br_op),
        .imm         (imm),
        .br_offs     (br_offs),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .waddr       (ds_rf_waddr),
        .rf_we       (rf_we),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .use_src1    (use_src1),
        .use_src2    (use_src2)
    );

    regfile #(
        .depth (reg_count)
    ) u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (raddr2),
        .rdata2 (rf_rdata2),
        .we     (ws_rf_we),
        .waddr  (ws_rf_waddr),
        .wdata  (ws_rf_wdata)
    );

    operand_bypass u_bypass (
        .raddr1          (raddr1),
        .raddr2          (raddr2),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .use_src1        (use_src1),
        .use_src2        (use_src2),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_alu_result   (es_alu_result),
        .es_res_from_mem (es_res_from_mem),
        .ms_rf_we        (ms_rf_we),
        .ms_rf_waddr     (ms_rf_waddr),
        .ms_rf_wdata     (ms_rf_wdata),
        .ws_rf_we        (ws_rf_we),
        .ws_rf_waddr     (ws_rf_waddr),
        .ws_rf_wdata     (ws_rf_wdata),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .load_stall      (load_stall)
    );

    branch_unit u_branch (
        .br_op      (br_op),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .pc         (ds_pc),
        .br_offs    (br_offs),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    // operands to execute
    assign ds_alu_src1  = src1_is_pc ? ds_pc : rj_value;
    assign ds_alu_src2  = src2_is_imm ? imm : rkd_value;
    assign ds_rkd_value = rkd_value;

    // no write leaves the stage without a valid handoff
    assign ds_rf_we = rf_we && ds_to_es_valid;

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit (
    input  decode_pkg::br_op_e br_op,
    input  decode_pkg::word_t  rj_value,
    input  decode_pkg::word_t  rkd_value,
    input  decode_pkg::word_t  pc,
    input  decode_pkg::word_t  br_offs,
    output logic               cond_taken,
    output decode_pkg::word_t  target
);
    import decode_pkg::*;

    logic  rj_eq_rd;
    logic  rj_lt_rd;
    logic  rj_ltu_rd;
    word_t base;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    always_comb begin
        case (br_op)
            br_beq:  cond_taken = rj_eq_rd;
            br_bne:  cond_taken = !rj_eq_rd;
            br_blt:  cond_taken = rj_lt_rd;
            br_bge:  cond_taken = !rj_lt_rd;
            br_bltu: cond_taken = rj_ltu_rd;
            br_bgeu: cond_taken = !rj_ltu_rd;
            br_b,
            br_bl,
            br_jirl: cond_taken = 1'b1;
            default: cond_taken = 1'b0;
        endcase
    end

    // jirl is register-relative, the rest pc-relative
    assign base   = (br_op == br_jirl) ? rj_value : pc;
    assign target = base + br_offs;

endmodule

// ==== logic/operand_bypass.sv ====
module operand_bypass (
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    input  logic                  use_src1,
    input  logic                  use_src2,
    input  logic                  es_rf_we,
    input  decode_pkg::reg_addr_t es_rf_waddr,
    input  decode_pkg::word_t     es_alu_result,
    input  logic                  es_res_from_mem,
    input  logic                  ms_rf_we,
    input  decode_pkg::reg_addr_t ms_rf_waddr,
    input  decode_pkg::word_t     ms_rf_wdata,
    input  logic                  ws_rf_we,
    input  decode_pkg::reg_addr_t ws_rf_waddr,
    input  decode_pkg::word_t     ws_rf_wdata,
    output decode_pkg::word_t     rj_value,
    output decode_pkg::word_t     rkd_value,
    output logic                  load_stall
);
    import decode_pkg::*;

    reg_addr_t raddr    [2];
    word_t     rf_rdata [2];
    word_t     value    [2];
    logic      used     [2];
    logic      es_hit   [2];
    logic      ms_hit   [2];
    logic      ws_hit   [2];

    assign raddr[0]    = raddr1;
    assign raddr[1]    = raddr2;
    assign rf_rdata[0] = rf_rdata1;
    assign rf_rdata[1] = rf_rdata2;
    assign used[0]     = use_src1;
    assign used[1]     = use_src2;

    // newest producer wins, r0 never forwarded
    for (genvar i = 0; i < 2; i++) begin : g_src
        assign es_hit[i] = es_rf_we && raddr[i] != '0 && es_rf_waddr == raddr[i];
        assign ms_hit[i] = ms_rf_we && raddr[i] != '0 && ms_rf_waddr == raddr[i];
        assign ws_hit[i] = ws_rf_we && raddr[i] != '0 && ws_rf_waddr == raddr[i];

        assign value[i] = es_hit[i] ? es_alu_result :
                          ms_hit[i] ? ms_rf_wdata   :
                          ws_hit[i] ? ws_rf_wdata   :
                                      rf_rdata[i];
    end

    assign rj_value  = value[0];
    assign rkd_value = value[1];

    // load data not ready until memory stage
    assign load_stall = es_res_from_mem &&
                        ((es_hit[0] && used[0]) || (es_hit[1] && used[1]));

endmodule

// ==== logic/regfile.sv ====
module regfile #(
    parameter int depth = decode_pkg::reg_count
) (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    output decode_pkg::word_t     rdata1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata2,
    input  logic                  we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata
);
    import decode_pkg::*;

    word_t regs [depth];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== logic/inst_decoder.sv ====
module inst_decoder (
    input  decode_pkg::word_t     inst,
    output decode_pkg::alu_op_e   alu_op,
    output decode_pkg::mem_op_e   mem_op,
    output decode_pkg::br_op_e    br_op,
    output decode_pkg::word_t     imm,
    output decode_pkg::word_t     br_offs,
    output decode_pkg::reg_addr_t raddr1,
    output decode_pkg::reg_addr_t raddr2,
    output decode_pkg::reg_addr_t waddr,
    output logic                  rf_we,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  use_src1,
    output logic                  use_src2
);
    import decode_pkg::*;

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    reg_addr_t  rd;
    reg_addr_t  rj;
    reg_addr_t  rk;
    word_t      imm_si12;
    word_t      imm_ui12;
    word_t      imm_ui5;
    word_t      imm_u20;
    word_t      offs16;
    word_t      offs26;
    logic       src_is_rd;
    logic       dst_is_r1;

    ////////////////////////////////////////////////////////////
    // fields
    ////////////////////////////////////////////////////////////
    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12 = {20'b0, inst[21:10]};
    assign imm_ui5  = {27'b0, inst[14:10]};
    assign imm_u20  = {inst[24:5], 12'b0};

    // offs26 is split across two fields, high part in [9:0]
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    ////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_op      = alu_none;
        mem_op      = mem_none;
        br_op       = br_none;
        imm         = '0;
        rf_we       = 1'b0;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        use_src1    = 1'b0;
        use_src2    = 1'b0;
        src_is_rd   = 1'b0;
        dst_is_r1   = 1'b0;
        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    // three-register group
                    case (op_19_15)
                        5'h00:   alu_op = alu_add;
                        5'h02:   alu_op = alu_sub;
                        5'h04:   alu_op = alu_slt;
                        5'h05:   alu_op = alu_sltu;
                        5'h08:   alu_op = alu_nor;
                        5'h09:   alu_op = alu_and;
                        5'h0a:   alu_op = alu_or;
                        5'h0b:   alu_op = alu_xor;
                        5'h0e:   alu_op = alu_sll;
                        5'h0f:   alu_op = alu_srl;
                        5'h10:   alu_op = alu_sra;
                        default: alu_op = alu_none;
                    endcase
                    use_src2 = (alu_op != alu_none);
                end else begin
                    if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                        case (op_19_15)
                            5'h01:   alu_op = alu_sll;
                            5'h09:   alu_op = alu_srl;
                            5'h11:   alu_op = alu_sra;
                            default: alu_op = alu_none;
                        endcase
                        imm = imm_ui5;
                    end else begin
                        case (op_25_22)
                            4'h8:    alu_op = alu_slt;
                            4'h9:    alu_op = alu_sltu;
                            4'ha:    alu_op = alu_add;
                            4'hd:    alu_op = alu_and;
                            4'he:    alu_op = alu_or;
                            4'hf:    alu_op = alu_xor;
                            default: alu_op = alu_none;
                        endcase
                        // logical forms zero-extend
                        imm = op_25_22[2] ? imm_ui12 : imm_si12;
                    end
                    src2_is_imm = (alu_op != alu_none);
                end
                rf_we    = (alu_op != alu_none);
                use_src1 = rf_we;
            end
            6'h0a: begin
                case (op_25_22)
                    4'h0:    mem_op = mem_ld_b;
                    4'h1:    mem_op = mem_ld_h;
                    4'h2:    mem_op = mem_ld_w;
                    4'h4:    mem_op = mem_st_b;
                    4'h5:    mem_op = mem_st_h;
                    4'h6:    mem_op = mem_st_w;
                    4'h8:    mem_op = mem_ld_bu;
                    4'h9:    mem_op = mem_ld_hu;
                    default: mem_op = mem_none;
                endcase
                if (mem_op != mem_none) begin
                    alu_op      = alu_add;
                    imm         = imm_si12;
                    src2_is_imm = 1'b1;
                    use_src1    = 1'b1;
                    // stores read rd as the data
                    src_is_rd   = (op_25_22[3:2] == 2'b01);
                    use_src2    = src_is_rd;
                    rf_we       = !src_is_rd;
                end
            end
            6'h05: begin
                if (!inst[25]) begin
                    alu_op      = alu_lui;
                    imm         = imm_u20;
                    src2_is_imm = 1'b1;
                    rf_we       = 1'b1;
                end
            end
            6'h07: begin
                if (!inst[25]) begin
                    alu_op      = alu_add;
                    imm         = imm_u20;
                    src1_is_pc  = 1'b1;
                    src2_is_imm = 1'b1;
                    rf_we       = 1'b1;
                end
            end
            6'h13: begin
                // link value pc + 4, target uses rj
                br_op       = br_jirl;
                alu_op      = alu_add;
                imm         = 32'd4;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                use_src1    = 1'b1;
                rf_we       = 1'b1;
            end
            6'h14: begin
                br_op = br_b;
            end
            6'h15: begin
                br_op       = br_bl;
                alu_op      = alu_add;
                imm         = 32'd4;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                dst_is_r1   = 1'b1;
                rf_we       = 1'b1;
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                case (op_31_26)
                    6'h16:   br_op = br_beq;
                    6'h17:   br_op = br_bne;
                    6'h18:   br_op = br_blt;
                    6'h19:   br_op = br_bge;
                    6'h1a:   br_op = br_bltu;
                    default: br_op = br_bgeu;
                endcase
                src_is_rd = 1'b1;
                use_src1  = 1'b1;
                use_src2  = 1'b1;
            end
            default: begin
                alu_op = alu_none;
            end
        endcase
    end

    assign br_offs = (br_op == br_b || br_op == br_bl) ? offs26 : offs16;

    assign raddr1 = rj;
    assign raddr2 = src_is_rd ? rd : rk;
    assign waddr  = dst_is_r1 ? 5'd1 : rd;

endmodule

// ==== logic/decode_pkg.sv ====
package decode_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    parameter int xlen      = 32;
    parameter int reg_count = 32;

    typedef logic [xlen-1:0]               word_t;
    typedef logic [$clog2(reg_count)-1:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////
    // opcodes handed to execute and fetch
    ////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        // passes src2 through, used by lu12i.w
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b,
        mem_ld_h,
        mem_ld_w,
        mem_ld_bu,
        mem_ld_hu,
        mem_st_b,
        mem_st_h,
        mem_st_w
    } mem_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_b,
        br_bl,
        br_jirl
    } br_op_e;

endpackage
